//--- hw/la_macros.svh
`ifndef LA_MACROS_SVH
`define LA_MACROS_SVH

// Datapath widths
`define LA_DATA_W       24
`define LA_RUN_W        8
`define LA_WORD_W       32
`define LA_LEVEL_W      8
`define LA_ADDR_W       15

// Capture buffer
`define LA_FIFO_DEPTH   128

// Register word indices, taken from address bits 11 to 2
`define LA_REG_MASK     10'd0
`define LA_REG_HTHR     10'd1
`define LA_REG_LTHR     10'd2
`define LA_REG_PKT      10'd3

// Reset values
`define LA_HTHR_RST     8'd64
`define LA_LTHR_RST     8'd16
`define LA_PKT_RST      8'd8
`define LA_UNMAPPED_RD  32'hFFFF_FFFF

`endif

//--- hw/la_pkg.sv
`include "la_macros.svh"

package la_pkg;

    typedef logic [`LA_DATA_W-1:0]  la_data_t;
    typedef logic [`LA_RUN_W-1:0]   la_run_t;
    // Run count in the top byte, masked probe data below
    typedef logic [`LA_WORD_W-1:0]  la_word_t;
    typedef logic [`LA_LEVEL_W-1:0] la_level_t;
    typedef logic [`LA_ADDR_W-1:0]  la_addr_t;

    // AXI-Lite master to slave
    typedef struct packed {
        logic                  awvalid;
        la_addr_t              awaddr;
        logic                  wvalid;
        logic [`LA_WORD_W-1:0] wdata;
        logic                  arvalid;
        la_addr_t              araddr;
        logic                  rready;
    } la_axil_req_t;

    // AXI-Lite slave to master
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  arready;
        logic                  rvalid;
        logic [`LA_WORD_W-1:0] rdata;
    } la_axil_rsp_t;

    typedef struct packed {
        la_data_t  enable_mask;
        la_level_t h_thresh;
        la_level_t l_thresh;
        la_level_t pkt_len;
    } la_cfg_t;

    typedef struct packed {
        la_word_t tdata;
        logic     tlast;
        logic     tvalid;
    } la_axis_t;

    typedef enum logic [2:0] {
        idle,
        read_data,
        read_done,
        write_data,
        write_done
    } la_csr_state_t;

endpackage

//--- hw/la_csr.sv
`include "la_macros.svh"

module la_csr (
    input  logic                 axi_clk,
    input  logic                 axi_reset_n,
    input  la_pkg::la_axil_req_t axil_req_i,
    output la_pkg::la_axil_rsp_t axil_rsp_o,
    output la_pkg::la_cfg_t      cfg_o
);

    la_pkg::la_csr_state_t state;
    la_pkg::la_addr_t      addr_q;
    logic [`LA_WORD_W-1:0] wdata_q;
    logic [`LA_WORD_W-1:0] rdata_q;
    logic [`LA_WORD_W-1:0] rd_value;
    logic [9:0]            reg_idx;
    logic                  awready_q;
    logic                  wready_q;
    logic                  arready_q;
    logic                  rvalid_q;
    la_pkg::la_cfg_t       cfg_q;

    assign reg_idx = addr_q[11:2];

    // Read mux, zero extended
    always_comb begin
        rd_value = '0;
        case (reg_idx)
            `LA_REG_MASK: rd_value[`LA_DATA_W-1:0]  = cfg_q.enable_mask;
            `LA_REG_HTHR: rd_value[`LA_LEVEL_W-1:0] = cfg_q.h_thresh;
            `LA_REG_LTHR: rd_value[`LA_LEVEL_W-1:0] = cfg_q.l_thresh;
            `LA_REG_PKT:  rd_value[`LA_LEVEL_W-1:0] = cfg_q.pkt_len;
            default:      rd_value = `LA_UNMAPPED_RD;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM and configuration registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge axi_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state             <= la_pkg::idle;
            awready_q         <= 1'b0;
            wready_q          <= 1'b0;
            arready_q         <= 1'b0;
            rvalid_q          <= 1'b0;
            cfg_q.enable_mask <= '0;
            cfg_q.h_thresh    <= `LA_HTHR_RST;
            cfg_q.l_thresh    <= `LA_LTHR_RST;
            cfg_q.pkt_len     <= `LA_PKT_RST;
        end else begin
            case (state)
                la_pkg::idle: begin
                    // Reads win over writes
                    if (axil_req_i.arvalid) begin
                        arready_q <= 1'b1;
                        state     <= la_pkg::read_data;
                    end else if (axil_req_i.awvalid && axil_req_i.wvalid) begin
                        awready_q <= 1'b1;
                        wready_q  <= 1'b1;
                        state     <= la_pkg::write_done;
                    end else if (axil_req_i.awvalid) begin
                        awready_q <= 1'b1;
                        state     <= la_pkg::write_data;
                    end
                end
                la_pkg::read_data: begin
                    arready_q <= 1'b0;
                    rvalid_q  <= 1'b1;
                    state     <= la_pkg::read_done;
                end
                la_pkg::read_done: begin
                    if (axil_req_i.rready) begin
                        rvalid_q <= 1'b0;
                        state    <= la_pkg::idle;
                    end
                end
                la_pkg::write_data: begin
                    awready_q <= 1'b0;
                    if (axil_req_i.wvalid) begin
                        wready_q <= 1'b1;
                        state    <= la_pkg::write_done;
                    end
                end
                la_pkg::write_done: begin
                    awready_q <= 1'b0;
                    wready_q  <= 1'b0;
                    state     <= la_pkg::idle;
                    // Unmapped index leaves everything as is
                    case (reg_idx)
                        `LA_REG_MASK: cfg_q.enable_mask <= wdata_q[`LA_DATA_W-1:0];
                        `LA_REG_HTHR: cfg_q.h_thresh    <= wdata_q[`LA_LEVEL_W-1:0];
                        `LA_REG_LTHR: cfg_q.l_thresh    <= wdata_q[`LA_LEVEL_W-1:0];
                        `LA_REG_PKT:  cfg_q.pkt_len     <= wdata_q[`LA_LEVEL_W-1:0];
                        default: ;
                    endcase
                end
                default: state <= la_pkg::idle;
            endcase
        end
    end

    // Address, write data and read data latches
    always_ff @(posedge axi_clk) begin
        case (state)
            la_pkg::idle: begin
                if (axil_req_i.arvalid) begin
                    addr_q <= axil_req_i.araddr;
                end else begin
                    addr_q  <= axil_req_i.awaddr;
                    wdata_q <= axil_req_i.wdata;
                end
            end
            la_pkg::write_data: begin
                if (axil_req_i.wvalid) begin
                    wdata_q <= axil_req_i.wdata;
                end
            end
            la_pkg::read_data: rdata_q <= rd_value;
            default: ;
        endcase
    end

    assign axil_rsp_o.awready = awready_q;
    assign axil_rsp_o.wready  = wready_q;
    assign axil_rsp_o.arready = arready_q;
    assign axil_rsp_o.rvalid  = rvalid_q;
    assign axil_rsp_o.rdata   = rdata_q;
    assign cfg_o              = cfg_q;

endmodule

//--- hw/la_capture.sv
module la_capture (
    input  logic              axi_clk,
    input  logic              axi_reset_n,
    input  la_pkg::la_data_t  probe_i,
    input  la_pkg::la_cfg_t   cfg_i,
    input  logic              fifo_full_i,
    output logic              push_o,
    output la_pkg::la_word_t  push_word_o
);

    // Longest run one word can report
    localparam la_pkg::la_run_t run_max = '1;

    la_pkg::la_data_t masked;
    la_pkg::la_data_t last_q;
    la_pkg::la_run_t  run_cnt;
    logic             active;
    logic             changed;
    logic             overflow;

    assign active   = |cfg_i.enable_mask;
    assign masked   = probe_i & cfg_i.enable_mask;
    assign changed  = active && (masked != last_q);
    // Run saturates without a change, report it and start over
    assign overflow = active && !changed && (run_cnt == run_max);

    //////////////////////////////////////////////////////////////////////
    // Change detection and run-length counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge axi_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            last_q  <= '0;
            run_cnt <= la_pkg::la_run_t'(1);
            push_o  <= 1'b0;
        end else begin
            // Words are lost while the buffer is full
            push_o <= (changed || overflow) && !fifo_full_i;
            if (!active || changed || overflow) begin
                run_cnt <= la_pkg::la_run_t'(1);
            end else begin
                run_cnt <= run_cnt + 1'b1;
            end
            if (changed) begin
                last_q <= masked;
            end
        end
    end

    // On a change the count belongs to the previous value
    // On overflow masked still equals last_q
    always_ff @(posedge axi_clk) begin
        if (changed || overflow) begin
            push_word_o <= {run_cnt, masked};
        end
    end

endmodule

//--- hw/la_fifo.sv
`include "la_macros.svh"

module la_fifo (
    input  logic              axi_clk,
    input  logic              axi_reset_n,
    input  logic              push_i,
    input  la_pkg::la_word_t  push_word_i,
    input  logic              pop_i,
    output la_pkg::la_word_t  head_word_o,
    output la_pkg::la_level_t level_o,
    output logic              full_o
);

    localparam int ptr_w = $clog2(`LA_FIFO_DEPTH);

    la_pkg::la_word_t  mem [`LA_FIFO_DEPTH];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [ptr_w-1:0]  rd_addr;
    la_pkg::la_level_t level_q;
    logic              push_ok;
    logic              pop_ok;

    assign full_o  = (level_q == la_pkg::la_level_t'(`LA_FIFO_DEPTH));
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && (level_q != '0);
    // Look ahead so the head register follows a pop back to back
    assign rd_addr = pop_ok ? rd_ptr + 1'b1 : rd_ptr;

    always_ff @(posedge axi_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: ;
            endcase
        end
    end

    // Inferred dual port memory with registered read
    always_ff @(posedge axi_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_word_i;
        end
        head_word_o <= mem[rd_addr];
    end

    assign level_o = level_q;

endmodule

//--- hw/la_stream_out.sv
module la_stream_out (
    input  logic              axi_clk,
    input  logic              axi_reset_n,
    input  la_pkg::la_cfg_t   cfg_i,
    input  la_pkg::la_word_t  head_word_i,
    input  la_pkg::la_level_t level_i,
    output logic              pop_o,
    output la_pkg::la_axis_t  axis_o,
    input  logic              tready_i,
    output logic              hpri_req_o
);

    typedef enum logic [1:0] {
        st_wait,
        st_fetch,
        st_send
    } pkt_state_t;

    pkt_state_t        state;
    la_pkg::la_level_t beat_cnt;
    logic              tvalid_q;
    logic              last_beat;
    logic              hpri_q;
    logic              pkt_ready;

    // Whole packet must sit in the buffer before it starts
    assign pkt_ready = (level_i != '0) && (level_i >= cfg_i.pkt_len);
    // A zero length acts as a single beat packet
    assign last_beat = (beat_cnt >= cfg_i.pkt_len);
    assign pop_o     = tvalid_q && tready_i;

    //////////////////////////////////////////////////////////////////////
    // Packet FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge axi_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state    <= st_wait;
            beat_cnt <= la_pkg::la_level_t'(1);
            tvalid_q <= 1'b0;
        end else begin
            case (state)
                st_wait: begin
                    beat_cnt <= la_pkg::la_level_t'(1);
                    if (pkt_ready) begin
                        state <= st_fetch;
                    end
                end
                // Head register catches up with the read pointer here
                st_fetch: begin
                    tvalid_q <= 1'b1;
                    state    <= st_send;
                end
                st_send: begin
                    if (tready_i) begin
                        if (last_beat) begin
                            tvalid_q <= 1'b0;
                            state    <= st_wait;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_wait;
            endcase
        end
    end

    // High priority request with hysteresis between the thresholds
    always_ff @(posedge axi_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            hpri_q <= 1'b0;
        end else if (level_i >= cfg_i.h_thresh) begin
            hpri_q <= 1'b1;
        end else if (level_i <= cfg_i.l_thresh) begin
            hpri_q <= 1'b0;
        end
    end

    // Head word only moves on a pop, so tdata holds while stalled
    assign axis_o.tdata  = head_word_i;
    assign axis_o.tvalid = tvalid_q;
    assign axis_o.tlast  = tvalid_q && last_beat;
    assign hpri_req_o    = hpri_q;

endmodule

//--- hw/logic_analyzer.sv
module logic_analyzer (
    input  logic                 axi_clk,
    input  logic                 axi_reset_n,
    input  la_pkg::la_axil_req_t axil_req_i,
    output la_pkg::la_axil_rsp_t axil_rsp_o,
    input  la_pkg::la_data_t     probe_i,
    output la_pkg::la_axis_t     axis_o,
    input  logic                 tready_i,
    output logic                 la_hpri_req_o
);

    la_pkg::la_cfg_t   cfg;
    la_pkg::la_word_t  push_word;
    la_pkg::la_word_t  head_word;
    la_pkg::la_level_t level;
    logic              push;
    logic              pop;
    logic              fifo_full;

    //////////////////////////////////////////////////////////////////////
    // Register file, capture, buffer, stream output
    //////////////////////////////////////////////////////////////////////
    la_csr u_csr (
        .axi_clk     (axi_clk),
        .axi_reset_n (axi_reset_n),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .cfg_o       (cfg)
    );

    la_capture u_capture (
        .axi_clk     (axi_clk),
        .axi_reset_n (axi_reset_n),
        .probe_i     (probe_i),
        .cfg_i       (cfg),
        .fifo_full_i (fifo_full),
        .push_o      (push),
        .push_word_o (push_word)
    );

    la_fifo u_fifo (
        .axi_clk     (axi_clk),
        .axi_reset_n (axi_reset_n),
        .push_i      (push),
        .push_word_i (push_word),
        .pop_i       (pop),
        .head_word_o (head_word),
        .level_o     (level),
        .full_o      (fifo_full)
    );

    la_stream_out u_stream_out (
        .axi_clk     (axi_clk),
        .axi_reset_n (axi_reset_n),
        .cfg_i       (cfg),
        .head_word_i (head_word),
        .level_i     (level),
        .pop_o       (pop),
        .axis_o      (axis_o),
        .tready_i    (tready_i),
        .hpri_req_o  (la_hpri_req_o)
    );

endmodule

//--- testbench/la_asserts.sv
module la_asserts (
    input  logic                 axi_clk,
    input  logic                 axi_reset_n,
    input  la_pkg::la_axil_req_t axil_req_i,
    input  la_pkg::la_axil_rsp_t axil_rsp_o,
    input  la_pkg::la_axis_t     axis_o,
    input  logic                 tready_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // A stalled beat keeps its valid and its data
    a_tvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        axis_o.tvalid && !tready_i |=> axis_o.tvalid && $stable(axis_o.tdata))
        else $error("tvalid or tdata changed before tready");

    // A stalled last beat stays the last beat
    a_tlast_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        axis_o.tlast && !tready_i |=> axis_o.tvalid && axis_o.tlast)
        else $error("tlast dropped before tready");

    // Read data waits for the master
    a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        axil_rsp_o.rvalid && !axil_req_i.rready |=> axil_rsp_o.rvalid)
        else $error("rvalid dropped before rready");

endmodule

//--- testbench/la_tb.sv
module la_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int tab_len = 13;
    localparam logic [23:0] tab_mask [tab_len] = '{
        24'hFFFFFF, 24'hFFFFFF, 24'hFFFFFF, 24'hFFFFFF, 24'hFFFFFF, 24'hFFFFFF, 24'hFFFFFF,
        24'h0000FF, 24'h0000FF, 24'h0000FF, 24'h0000FF, 24'h0000FF, 24'h0000FF};
    localparam logic [23:0] tab_data [tab_len] = '{
        24'h123456, 24'hABCDEF, 24'h000001, 24'h800000, 24'h5A5A5A, 24'h0F0F0F, 24'h00003C,
        24'h12343C, 24'h99993C, 24'h9999C3, 24'h0000C3, 24'h777711, 24'h000022};
    // The 600 cycle hold yields two overflow words, then a count of 90
    localparam int tab_hold [tab_len] = '{5, 3, 20, 7, 12, 600, 9, 6, 4, 8, 5, 10, 3};

    logic                 axi_clk;
    logic                 axi_reset_n;
    la_pkg::la_axil_req_t axil_req;
    la_pkg::la_axil_rsp_t axil_rsp;
    la_pkg::la_data_t     probe;
    la_pkg::la_axis_t     axis;
    logic                 tready;
    logic                 hpri;

    int               errors = 0;
    integer           seed = 11;
    int               tready_mode = 1;
    int               tready_sel = 1;
    int               cur_pkt = 8;
    int               beat_no = 0;
    la_pkg::la_word_t exp_q [$];
    bit               chk_q [$];
    la_pkg::la_data_t last_m = '0;
    int               run = 0;
    bit               skip = 1'b1;

    logic_analyzer dut (
        .axi_clk       (axi_clk),
        .axi_reset_n   (axi_reset_n),
        .axil_req_i    (axil_req),
        .axil_rsp_o    (axil_rsp),
        .probe_i       (probe),
        .axis_o        (axis),
        .tready_i      (tready),
        .la_hpri_req_o (hpri)
    );

    bind logic_analyzer la_asserts u_asserts (
        .axi_clk     (axi_clk),
        .axi_reset_n (axi_reset_n),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .axis_o      (axis_o),
        .tready_i    (tready_i)
    );

    initial begin
        axi_clk = 1'b0;
        forever #10 axi_clk = ~axi_clk;
    end

    task automatic tick();
        @(posedge axi_clk);
        #2;
    endtask

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // Wait for one of the AXI-Lite response flags, bounded
    task automatic wait_flag(int which, string what);
        int n;
        n = 0;
        do begin
            tick();
            n++;
        end while (!(which == 0 ? axil_rsp.awready : which == 1 ? axil_rsp.wready :
                     which == 2 ? axil_rsp.arready : axil_rsp.rvalid) && n < 50);
        if (n >= 50) begin
            errors++;
            $display("Timeout at %0t ns waiting for %s", $time, what);
        end
    endtask

    task automatic axil_write(logic [14:0] addr, logic [31:0] data, bit together);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = together;
        wait_flag(0, "awready");
        axil_req.awvalid = 1'b0;
        if (!together) begin
            axil_req.wvalid = 1'b1;
            wait_flag(1, "wready");
        end
        axil_req.wvalid = 1'b0;
        tick();
    endtask

    task automatic axil_read(logic [14:0] addr, string name, logic [31:0] exp);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        wait_flag(2, "arready");
        axil_req.arvalid = 1'b0;
        wait_flag(3, "rvalid");
        compare(name, axil_rsp.rdata, exp);
        // Master keeps the read data waiting one cycle
        tick();
        axil_req.rready = 1'b1;
        tick();
        axil_req.rready = 1'b0;
    endtask

    // Reference run-length rules, one call per probe cycle
    task automatic model_cycle(la_pkg::la_data_t m);
        if (m != last_m || run == 255) begin
            exp_q.push_back({m != last_m ? run[7:0] : 8'd255, m});
            chk_q.push_back(!skip);
            skip   = 1'b0;
            last_m = m;
            run    = 1;
        end else begin
            run++;
        end
    endtask

    task automatic drive_cycle(la_pkg::la_data_t value, la_pkg::la_data_t mask);
        probe = value;
        model_cycle(value & mask);
        tick();
    endtask

    task automatic wait_drain(int limit);
        int n;
        n = 0;
        while (exp_q.size() >= cur_pkt && n < limit) begin
            tick();
            n++;
        end
        if (n >= limit) begin
            errors++;
            $display("Timeout at %0t ns, stream did not drain", $time);
        end
    endtask

    // Tready source, mode taken at the edge and driven just after it
    always @(posedge axi_clk) begin
        tready_sel = tready_mode;
        #2;
        tready = (tready_sel == 2) ? (($random(seed) & 3) != 0) : (tready_sel == 1);
    end

    //////////////////////////////////////////////////////////////////////
    // Stream checker
    //////////////////////////////////////////////////////////////////////
    always @(posedge axi_clk) begin
        if (axi_reset_n && axis.tvalid && tready) begin
            beat_no++;
            compare("tlast", axis.tlast, beat_no == cur_pkt);
            if (beat_no == cur_pkt) begin
                beat_no = 0;
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected stream word %h at %0t ns", axis.tdata, $time);
            end else begin
                compare("tdata[23:0]", axis.tdata[23:0], exp_q[0][23:0]);
                if (chk_q[0]) begin
                    compare("tdata[31:24]", axis.tdata[31:24], exp_q[0][31:24]);
                end
                void'(exp_q.pop_front());
                void'(chk_q.pop_front());
            end
        end
    end

    initial begin
        int n;
        la_pkg::la_data_t mask;
        bit tog;
        axil_req    = '0;
        probe       = '0;
        tready      = 1'b1;
        axi_reset_n = 1'b0;
        repeat (8) @(posedge axi_clk);
        #2;
        axi_reset_n = 1'b1;
        tick();

        // Register reset values and read back
        axil_read(15'h000, "mask", 32'h0);
        axil_read(15'h004, "h_thresh", 32'd64);
        axil_read(15'h008, "l_thresh", 32'd16);
        axil_read(15'h00C, "pkt_len", 32'd8);
        axil_read(15'h010, "unmapped", 32'hFFFF_FFFF);
        axil_write(15'h000, 32'h00AB_CDEF, 1'b1);
        axil_read(15'h000, "mask", 32'h00AB_CDEF);
        axil_write(15'h000, 32'h0, 1'b0);
        axil_read(15'h000, "mask", 32'h0);
        axil_write(15'h004, 32'd40, 1'b0);
        axil_write(15'h008, 32'd10, 1'b1);
        axil_write(15'h00C, 32'd4, 1'b0);
        cur_pkt = 4;
        axil_write(15'h010, 32'd99, 1'b1);
        axil_read(15'h000, "mask", 32'h0);
        axil_read(15'h004, "h_thresh", 32'd40);
        axil_read(15'h008, "l_thresh", 32'd10);
        axil_read(15'h00C, "pkt_len", 32'd4);

        // Capture table with random stalls on the stream
        tready_mode = 2;
        mask = '0;
        for (int i = 0; i < tab_len; i++) begin
            if (tab_mask[i] != mask) begin
                mask = tab_mask[i];
                axil_write(15'h000, {8'h0, mask}, 1'b1);
                skip = 1'b1;
            end
            for (int c = 0; c < tab_hold[i]; c++) begin
                drive_cycle(tab_data[i], mask);
            end
        end
        wait_drain(2000);

        ////////////////////////////////////////////////////////////////////
        // High-priority request hysteresis
        ////////////////////////////////////////////////////////////////////
        tready_mode = 0;
        skip = 1'b1;
        tog  = 1'b0;
        n    = 0;
        while (!hpri && n < 200) begin
            drive_cycle(tog ? 24'h0000AA : 24'h000055, mask);
            tog = ~tog;
            n++;
        end
        if (!hpri) begin
            errors++;
            $display("High-priority request never rose at %0t ns", $time);
        end else if (exp_q.size() < 40 || exp_q.size() > 43) begin
            errors++;
            $display("High-priority request rose at level %0d", exp_q.size());
        end
        tready_mode = 1;
        n = 0;
        while (hpri && n < 400) begin
            tick();
            n++;
        end
        if (hpri) begin
            errors++;
            $display("High-priority request never fell at %0t ns", $time);
        end else if (exp_q.size() < 8 || exp_q.size() > 10) begin
            errors++;
            $display("High-priority request fell at level %0d", exp_q.size());
        end
        for (int c = 0; c < 60; c++) begin
            tick();
            if (hpri) begin
                errors++;
                $display("High-priority request rose again at %0t ns", $time);
            end
        end
        wait_drain(400);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/la_pkg.sv
hw/la_csr.sv
hw/la_capture.sv
hw/la_fifo.sv
hw/la_stream_out.sv
hw/logic_analyzer.sv
testbench/la_asserts.sv
testbench/la_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the logic analyzer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module la_tb -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vla_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -q "^ALL TESTS PASSED$" || exit 1
exit 0
